// File: design/vcosh_macros.svh
// Fixed point is Q15.16 in 32 bits and the register map covers four word-aligned offsets only
`ifndef VCOSH_MACROS_SVH
`define VCOSH_MACROS_SVH

//////////////////////////////
// Number format
//////////////////////////////

// Data word and fraction bits
`define VCOSH_DATA_W 32
`define VCOSH_FRAC_W 16

// Vector length register width
`define VCOSH_SIZE_W 16

//////////////////////////////
// Series
//////////////////////////////

// Terms after the constant one
`define VCOSH_TERMS 3

// 1/2, 1/12 and 1/30 in Q16, applied after each x squared step
`define VCOSH_RECIP_1 32768
`define VCOSH_RECIP_2 5461
`define VCOSH_RECIP_3 2185

//////////////////////////////
// Register map
//////////////////////////////

`define VCOSH_ADDR_W      4
`define VCOSH_ADDR_CTRL   4'h0
`define VCOSH_ADDR_SIZE   4'h4
`define VCOSH_ADDR_STATUS 4'h8
`define VCOSH_ADDR_COUNT  4'hC

`endif

// File: design/vcosh_pkg.sv
// Enum values carry a prefix per type because all of them share the package scope
`default_nettype none

package vcosh_pkg;

  //////////////////////////////
  // Vector sequencer
  //////////////////////////////

  // Wait for start, take one element, wait for the scalar result
  typedef enum logic [1:0] {
    SEQ_IDLE      = 2'd0,
    SEQ_WAIT_IN   = 2'd1,
    SEQ_WAIT_CALC = 2'd2
  } seq_state_t;

  //////////////////////////////
  // Scalar cosh unit
  //////////////////////////////

  // One square, then x2 and reciprocal steps alternate per term
  typedef enum logic [1:0] {
    COSH_IDLE      = 2'd0,
    COSH_SQUARE    = 2'd1,
    COSH_MUL_X2    = 2'd2,
    COSH_MUL_RECIP = 2'd3
  } cosh_state_t;

  //////////////////////////////
  // AXI4-Lite
  //////////////////////////////

  // Only the two codes this slave can return
  typedef enum logic [1:0] {
    AXI_OKAY   = 2'b00,
    AXI_SLVERR = 2'b10
  } axi_resp_t;

endpackage

`default_nettype wire

// File: design/vcosh_csr.sv
// One AXI4-Lite transaction per channel at a time and START is dropped while busy or with SIZE zero
`timescale 1ns/1ns
`default_nettype none

`include "vcosh_macros.svh"

module vcosh_csr (
  input  logic                         CLK,
  input  logic                         RST,

  // AXI4-Lite write address and data
  input  logic [`VCOSH_ADDR_W-1:0]     s_axi_awaddr,
  input  logic                         s_axi_awvalid,
  output logic                         s_axi_awready,
  input  logic [`VCOSH_DATA_W-1:0]     s_axi_wdata,
  input  logic [`VCOSH_DATA_W/8-1:0]   s_axi_wstrb,
  input  logic                         s_axi_wvalid,
  output logic                         s_axi_wready,

  // AXI4-Lite write response
  output vcosh_pkg::axi_resp_t         s_axi_bresp,
  output logic                         s_axi_bvalid,
  input  logic                         s_axi_bready,

  // AXI4-Lite read
  input  logic [`VCOSH_ADDR_W-1:0]     s_axi_araddr,
  input  logic                         s_axi_arvalid,
  output logic                         s_axi_arready,
  output logic [`VCOSH_DATA_W-1:0]     s_axi_rdata,
  output vcosh_pkg::axi_resp_t         s_axi_rresp,
  output logic                         s_axi_rvalid,
  input  logic                         s_axi_rready,

  // Sequencer control
  output logic                         start,
  output logic [`VCOSH_SIZE_W-1:0]     size,
  input  logic                         busy,
  input  logic                         elem_done,
  input  logic                         run_done
);

  import vcosh_pkg::*;

  localparam int W  = `VCOSH_DATA_W;
  localparam int SW = `VCOSH_SIZE_W;

  // Software visible registers
  logic [SW-1:0] size_reg;
  logic          done_reg;
  logic [W-1:0]  count_reg;

  // Decoded channel events
  logic          wr_fire;
  logic          rd_fire;
  logic          start_req;
  axi_resp_t     wr_resp;
  axi_resp_t     rd_resp;
  logic [W-1:0]  rd_data;

  // Handshake edges, ready is only high after both valids were seen
  assign wr_fire = s_axi_awready && s_axi_awvalid && s_axi_wvalid;
  assign rd_fire = s_axi_arready && s_axi_arvalid;

  // Start bit lives in the low byte lane
  assign start_req = wr_fire && (s_axi_awaddr == `VCOSH_ADDR_CTRL) &&
                     s_axi_wstrb[0] && s_axi_wdata[0];

  // Write decode, anything off the map is an error
  always_comb begin
    wr_resp = AXI_OKAY;
    case (s_axi_awaddr)
      `VCOSH_ADDR_CTRL, `VCOSH_ADDR_SIZE, `VCOSH_ADDR_STATUS, `VCOSH_ADDR_COUNT: ;
      default: wr_resp = AXI_SLVERR;
    endcase
  end

  // Read mux, CTRL reads back as zero since START self clears
  always_comb begin
    rd_data = '0;
    rd_resp = AXI_OKAY;
    case (s_axi_araddr)
      `VCOSH_ADDR_CTRL:   rd_data = '0;
      `VCOSH_ADDR_SIZE:   rd_data = {{(W-SW){1'b0}}, size_reg};
      `VCOSH_ADDR_STATUS: rd_data = {{(W-2){1'b0}}, done_reg, busy};
      `VCOSH_ADDR_COUNT:  rd_data = count_reg;
      default:            rd_resp = AXI_SLVERR;
    endcase
  end

  //////////////////////////////
  // Write channel
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      s_axi_bresp   <= AXI_OKAY;
    end else begin
      // Single cycle ready pulse on both channels together
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      if (s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid) begin
        s_axi_awready <= 1'b1;
        s_axi_wready  <= 1'b1;
      end
      // Response follows the handshake, held until accepted
      if (wr_fire) begin
        s_axi_bvalid <= 1'b1;
        s_axi_bresp  <= wr_resp;
      end else if (s_axi_bvalid && s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Read channel
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
      s_axi_rresp   <= AXI_OKAY;
    end else begin
      s_axi_arready <= s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;
      if (rd_fire) begin
        s_axi_rvalid <= 1'b1;
        s_axi_rresp  <= rd_resp;
      end else if (s_axi_rvalid && s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  // Read data captured with the address handshake
  always_ff @(posedge CLK) begin
    if (rd_fire) begin
      s_axi_rdata <= rd_data;
    end
  end

  //////////////////////////////
  // Registers and run control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_reg  <= '0;
      size      <= '0;
      start     <= 1'b0;
      done_reg  <= 1'b0;
      count_reg <= '0;
    end else begin
      start <= 1'b0;

      // SIZE honours the two low byte strobes
      if (wr_fire && (s_axi_awaddr == `VCOSH_ADDR_SIZE)) begin
        if (s_axi_wstrb[0]) size_reg[7:0]  <= s_axi_wdata[7:0];
        if (s_axi_wstrb[1]) size_reg[15:8] <= s_axi_wdata[15:8];
      end

      // Pulse pending counts as busy, the sequencer sees it one cycle late
      if (start_req && !busy && !start && (size_reg != '0)) begin
        start     <= 1'b1;
        size      <= size_reg;
        done_reg  <= 1'b0;
        count_reg <= '0;
      end else begin
        if (run_done)  done_reg  <= 1'b1;
        if (elem_done) count_reg <= count_reg + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/scalar_cosh.sv
// Valid for |x| below 4.0 only, one element at a time, result is valid in the cycle ready is high
`timescale 1ns/1ns
`default_nettype none

`include "vcosh_macros.svh"

module scalar_cosh (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            start,
  input  logic signed [`VCOSH_DATA_W-1:0] x,
  output logic                            ready,
  output logic signed [`VCOSH_DATA_W-1:0] result
);

  import vcosh_pkg::*;

  localparam int W = `VCOSH_DATA_W;

  // 1.0 in Q16
  localparam logic signed [W-1:0] ONE = 1 << `VCOSH_FRAC_W;

  localparam logic signed [W-1:0] RECIP_1 = `VCOSH_RECIP_1;
  localparam logic signed [W-1:0] RECIP_2 = `VCOSH_RECIP_2;
  localparam logic signed [W-1:0] RECIP_3 = `VCOSH_RECIP_3;

  localparam logic [1:0] TERM_LAST = 2'(`VCOSH_TERMS - 1);

  cosh_state_t           state;
  logic [1:0]            term_cnt;

  // Operands and running values
  logic signed [W-1:0]   x_r;
  logic signed [W-1:0]   x2_r;
  logic signed [W-1:0]   term_r;
  logic signed [W-1:0]   acc_r;

  // Shared multiplier
  logic signed [W-1:0]   recip;
  logic signed [W-1:0]   mul_a;
  logic signed [W-1:0]   mul_b;
  logic signed [2*W-1:0] prod;
  logic signed [2*W-1:0] prod_sh;
  logic signed [W-1:0]   mul_q;

  // Reciprocal for the term being built
  always_comb begin
    case (term_cnt)
      2'd0:    recip = RECIP_1;
      2'd1:    recip = RECIP_2;
      default: recip = RECIP_3;
    endcase
  end

  // Operand select per step
  always_comb begin
    mul_a = term_r;
    mul_b = x2_r;
    case (state)
      COSH_SQUARE: begin
        mul_a = x_r;
        mul_b = x_r;
      end
      COSH_MUL_RECIP: mul_b = recip;
      default: ;
    endcase
    // Full 64 bit product, then back to Q16
    prod    = mul_a * mul_b;
    prod_sh = prod >>> `VCOSH_FRAC_W;
    mul_q   = prod_sh[W-1:0];
  end

  //////////////////////////////
  // Step sequencing
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= COSH_IDLE;
      term_cnt <= '0;
      ready    <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        COSH_IDLE: if (start) state <= COSH_SQUARE;
        COSH_SQUARE: begin
          term_cnt <= '0;
          state    <= COSH_MUL_X2;
        end
        COSH_MUL_X2: state <= COSH_MUL_RECIP;
        COSH_MUL_RECIP: begin
          // Last term lands in acc_r on this same edge
          if (term_cnt == TERM_LAST) begin
            ready <= 1'b1;
            state <= COSH_IDLE;
          end else begin
            term_cnt <= term_cnt + 1'b1;
            state    <= COSH_MUL_X2;
          end
        end
        default: state <= COSH_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      COSH_IDLE: if (start) x_r <= x;
      COSH_SQUARE: begin
        x2_r   <= mul_q;
        term_r <= ONE;
        acc_r  <= ONE;
      end
      COSH_MUL_X2: term_r <= mul_q;
      COSH_MUL_RECIP: begin
        term_r <= mul_q;
        acc_r  <= acc_r + mul_q;
      end
      default: ;
    endcase
  end

  assign result = acc_r;

endmodule

`default_nettype wire

// File: design/vector_cosh.sv
// Output has no back-pressure and size must stay stable and nonzero for the whole run
`timescale 1ns/1ns
`default_nettype none

`include "vcosh_macros.svh"

module vector_cosh (
  input  logic                            CLK,
  input  logic                            RST,

  // Run control
  input  logic                            start,
  input  logic [`VCOSH_SIZE_W-1:0]        size,

  // Input stream
  input  logic signed [`VCOSH_DATA_W-1:0] in_data,
  input  logic                            in_valid,
  output logic                            in_ready,

  // Output stream
  output logic signed [`VCOSH_DATA_W-1:0] out_data,
  output logic                            out_valid,

  // Status towards the register block
  output logic                            busy,
  output logic                            elem_done,
  output logic                            run_done
);

  import vcosh_pkg::*;

  localparam int W = `VCOSH_DATA_W;

  seq_state_t                 state;
  logic [`VCOSH_SIZE_W-1:0]   index;
  logic                       last_elem;
  logic                       accept;

  // Scalar unit hookup
  logic                       cosh_start;
  logic                       cosh_ready;
  logic signed [W-1:0]        cosh_x;
  logic signed [W-1:0]        cosh_result;

  // One idle input cycle follows every result
  assign in_ready  = (state == SEQ_WAIT_IN) && !out_valid;
  assign accept    = in_valid && in_ready;
  assign last_elem = (index == size - 1'b1);
  assign busy      = (state != SEQ_IDLE);
  assign elem_done = out_valid;

  //////////////////////////////
  // Sequencer FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= SEQ_IDLE;
      index      <= '0;
      cosh_start <= 1'b0;
      out_valid  <= 1'b0;
      run_done   <= 1'b0;
    end else begin
      cosh_start <= 1'b0;
      out_valid  <= 1'b0;
      run_done   <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            index <= '0;
            state <= SEQ_WAIT_IN;
          end
        end
        SEQ_WAIT_IN: begin
          if (accept) begin
            cosh_start <= 1'b1;
            state      <= SEQ_WAIT_CALC;
          end
        end
        SEQ_WAIT_CALC: begin
          if (cosh_ready) begin
            out_valid <= 1'b1;
            // Run ends with its last result
            if (last_elem) begin
              run_done <= 1'b1;
              state    <= SEQ_IDLE;
            end else begin
              index <= index + 1'b1;
              state <= SEQ_WAIT_IN;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // Element and result registers
  always_ff @(posedge CLK) begin
    if (accept) cosh_x <= in_data;
    if ((state == SEQ_WAIT_CALC) && cosh_ready) out_data <= cosh_result;
  end

  scalar_cosh u_scalar_cosh (
    .CLK    (CLK),
    .RST    (RST),
    .start  (cosh_start),
    .x      (cosh_x),
    .ready  (cosh_ready),
    .result (cosh_result)
  );

endmodule

`default_nettype wire

// File: design/vcosh_top.sv
// Consumer must always take out_data when out_valid is high and inputs must stay below 4.0
`timescale 1ns/1ns
`default_nettype none

`include "vcosh_macros.svh"

module vcosh_top (
  input  logic                            CLK,
  input  logic                            RST,

  // AXI4-Lite slave
  input  logic [`VCOSH_ADDR_W-1:0]        s_axi_awaddr,
  input  logic                            s_axi_awvalid,
  output logic                            s_axi_awready,
  input  logic [`VCOSH_DATA_W-1:0]        s_axi_wdata,
  input  logic [`VCOSH_DATA_W/8-1:0]      s_axi_wstrb,
  input  logic                            s_axi_wvalid,
  output logic                            s_axi_wready,
  output vcosh_pkg::axi_resp_t            s_axi_bresp,
  output logic                            s_axi_bvalid,
  input  logic                            s_axi_bready,
  input  logic [`VCOSH_ADDR_W-1:0]        s_axi_araddr,
  input  logic                            s_axi_arvalid,
  output logic                            s_axi_arready,
  output logic [`VCOSH_DATA_W-1:0]        s_axi_rdata,
  output vcosh_pkg::axi_resp_t            s_axi_rresp,
  output logic                            s_axi_rvalid,
  input  logic                            s_axi_rready,

  // Element streams
  input  logic signed [`VCOSH_DATA_W-1:0] in_data,
  input  logic                            in_valid,
  output logic                            in_ready,
  output logic signed [`VCOSH_DATA_W-1:0] out_data,
  output logic                            out_valid
);

  // Register block to sequencer
  logic                     start;
  logic [`VCOSH_SIZE_W-1:0] size;

  // Sequencer back to register block
  logic                     busy;
  logic                     elem_done;
  logic                     run_done;

  vcosh_csr u_csr (
    .CLK           (CLK),
    .RST           (RST),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .start         (start),
    .size          (size),
    .busy          (busy),
    .elem_done     (elem_done),
    .run_done      (run_done)
  );

  vector_cosh u_vector_cosh (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .size      (size),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .busy      (busy),
    .elem_done (elem_done),
    .run_done  (run_done)
  );

endmodule

`default_nettype wire

// File: verification/vcosh_tb.sv
// Random inputs stay inside +-2.0 and the consumer side never stalls
`timescale 1ns/1ns
`default_nettype none

`include "vcosh_macros.svh"

module vcosh_tb;

  import vcosh_pkg::*;

  localparam int AXI_TIMEOUT    = 20;
  localparam int STREAM_TIMEOUT = 40;
  localparam int POLL_LIMIT     = 100;
  localparam int LATENCY        = 9;
  localparam int ONE_Q          = 1 << `VCOSH_FRAC_W;

  logic CLK = 1'b0;
  logic RST;

  // AXI4-Lite master side
  logic [`VCOSH_ADDR_W-1:0]   s_axi_awaddr;
  logic                       s_axi_awvalid;
  logic                       s_axi_awready;
  logic [`VCOSH_DATA_W-1:0]   s_axi_wdata;
  logic [`VCOSH_DATA_W/8-1:0] s_axi_wstrb;
  logic                       s_axi_wvalid;
  logic                       s_axi_wready;
  axi_resp_t                  s_axi_bresp;
  logic                       s_axi_bvalid;
  logic                       s_axi_bready;
  logic [`VCOSH_ADDR_W-1:0]   s_axi_araddr;
  logic                       s_axi_arvalid;
  logic                       s_axi_arready;
  logic [`VCOSH_DATA_W-1:0]   s_axi_rdata;
  axi_resp_t                  s_axi_rresp;
  logic                       s_axi_rvalid;
  logic                       s_axi_rready;

  // Element streams
  logic signed [`VCOSH_DATA_W-1:0] in_data;
  logic                            in_valid;
  logic                            in_ready;
  logic signed [`VCOSH_DATA_W-1:0] out_data;
  logic                            out_valid;

  int seed = 32'h48480fe2;
  int fail_count = 0;
  int edge_cnt = 0;
  int out_count = 0;

  // Inputs of the next run
  int stim [0:15];

  // Accepted elements not yet produced and their accepting edges
  int pend_data [$];
  int pend_edge [$];

  // Every output seen in arrival order
  int out_log [$];

  vcosh_top dut0 (
    .CLK           (CLK),
    .RST           (RST),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .in_data       (in_data),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .out_data      (out_data),
    .out_valid     (out_valid)
  );

  // 100 ns clock
  always #50 CLK = ~CLK;

  always @(posedge CLK) edge_cnt = edge_cnt + 1;

  //////////////////////////////
  // Failure reporting
  //////////////////////////////

  task automatic abort_run(input string line);
    fail_count++;
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_fail(input string msg);
    abort_run($sformatf("[FAIL] %0t: %s", $time, msg));
  endtask

  task automatic timeout_fail(input string what);
    abort_run($sformatf("Timed out while waiting for %s", what));
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Q16 product formed in 64 bits and kept to 32 bits
  function automatic int qmul(input int a, input int b);
    longint p;
    p = longint'(a) * longint'(b);
    return int'(p >>> `VCOSH_FRAC_W);
  endfunction

  // 1 + x^2/2 + x^4/24 + x^6/720 with each term built from the one before
  function automatic int cosh_model(input int x);
    int recip [0:2];
    int sq;
    int term;
    int acc;
    recip[0] = `VCOSH_RECIP_1;
    recip[1] = `VCOSH_RECIP_2;
    recip[2] = `VCOSH_RECIP_3;
    sq   = qmul(x, x);
    term = ONE_Q;
    acc  = ONE_Q;
    for (int k = 0; k < `VCOSH_TERMS; k++) begin
      term = qmul(term, sq);
      term = qmul(term, recip[k]);
      acc  = acc + term;
    end
    return acc;
  endfunction

  // Uniform over the open range -2.0 to +2.0
  function automatic int rand_fixed();
    int r;
    r = $random(seed);
    return r % (2 * ONE_Q);
  endfunction

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return r % n;
  endfunction

  //////////////////////////////
  // Stream monitor
  //////////////////////////////

  task automatic check_output();
    int x;
    int acc_edge;
    int exp_v;
    assert (pend_data.size() != 0)
      else check_fail("out_valid with no element pending");
    x        = pend_data.pop_front();
    acc_edge = pend_edge.pop_front();
    exp_v    = cosh_model(x);
    assert (out_data == exp_v)
      else check_fail($sformatf("cosh(%0d) gave %0d, expected %0d", x, out_data, exp_v));
    assert (edge_cnt - acc_edge == LATENCY)
      else check_fail($sformatf("output %0d cycles after accept, expected %0d",
                                edge_cnt - acc_edge, LATENCY));
    out_log.push_back(out_data);
    out_count++;
  endtask

  // An accept seen mid cycle lands on the next edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (out_valid) check_output();
      assert (!(in_ready && (pend_data.size() != 0)))
        else check_fail("in_ready high while a result is pending");
      if (in_valid && in_ready) begin
        pend_data.push_back(in_data);
        pend_edge.push_back(edge_cnt + 1);
      end
    end
  end

  //////////////////////////////
  // AXI4-Lite master
  //////////////////////////////

  task automatic axi_write(input logic [`VCOSH_ADDR_W-1:0] addr, input logic [31:0] data,
                           output axi_resp_t resp);
    int waited;
    @(posedge CLK);
    s_axi_awaddr  <= addr;
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= 4'hF;
    s_axi_wvalid  <= 1'b1;
    waited = 0;
    do begin
      @(negedge CLK);
      waited++;
      if (waited > AXI_TIMEOUT) timeout_fail("awready and wready");
    end while (!s_axi_awready);
    // Both ready lines pulse together
    assert (s_axi_wready)
      else check_fail("wready low while awready is high");
    // Handshake edge
    @(posedge CLK);
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    s_axi_bready  <= 1'b1;
    waited = 0;
    do begin
      @(negedge CLK);
      waited++;
      if (waited > AXI_TIMEOUT) timeout_fail("bvalid");
    end while (!s_axi_bvalid);
    resp = s_axi_bresp;
    @(posedge CLK);
    s_axi_bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [`VCOSH_ADDR_W-1:0] addr, output logic [31:0] data,
                          output axi_resp_t resp);
    int waited;
    @(posedge CLK);
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
    waited = 0;
    do begin
      @(negedge CLK);
      waited++;
      if (waited > AXI_TIMEOUT) timeout_fail("arready");
    end while (!s_axi_arready);
    @(posedge CLK);
    s_axi_arvalid <= 1'b0;
    s_axi_rready  <= 1'b1;
    waited = 0;
    do begin
      @(negedge CLK);
      waited++;
      if (waited > AXI_TIMEOUT) timeout_fail("rvalid");
    end while (!s_axi_rvalid);
    data = s_axi_rdata;
    resp = s_axi_rresp;
    @(posedge CLK);
    s_axi_rready <= 1'b0;
  endtask

  task automatic write_ok(input logic [`VCOSH_ADDR_W-1:0] addr, input logic [31:0] data);
    axi_resp_t resp;
    axi_write(addr, data, resp);
    assert (resp == AXI_OKAY)
      else check_fail($sformatf("write to 0x%0h gave response %0d", addr, resp));
  endtask

  task automatic expect_read(input logic [`VCOSH_ADDR_W-1:0] addr, input logic [31:0] exp_v,
                             input string what);
    logic [31:0] data;
    axi_resp_t   resp;
    axi_read(addr, data, resp);
    assert (resp == AXI_OKAY)
      else check_fail($sformatf("%s read gave response %0d", what, resp));
    assert (data == exp_v)
      else check_fail($sformatf("%s read 0x%08h, expected 0x%08h", what, data, exp_v));
  endtask

  //////////////////////////////
  // Run helpers
  //////////////////////////////

  task automatic start_run(input int n);
    write_ok(`VCOSH_ADDR_SIZE, n);
    write_ok(`VCOSH_ADDR_CTRL, 32'h1);
  endtask

  // Elements first to first+n-1 with 0 to max_gap idle cycles before each
  task automatic drive_stream(input int first, input int n, input int max_gap);
    int gap;
    int waited;
    @(posedge CLK);
    for (int i = 0; i < n; i++) begin
      gap = (max_gap > 0) ? rand_below(max_gap + 1) : 0;
      repeat (gap) begin
        in_valid <= 1'b0;
        @(posedge CLK);
      end
      in_valid <= 1'b1;
      in_data  <= stim[first + i];
      waited = 0;
      do begin
        @(negedge CLK);
        waited++;
        if (waited > STREAM_TIMEOUT) timeout_fail("in_ready");
      end while (!in_ready);
      // Accepting edge
      @(posedge CLK);
    end
    in_valid <= 1'b0;
  endtask

  task automatic wait_outputs(input int target);
    int waited;
    waited = 0;
    while (out_count < target) begin
      @(negedge CLK);
      waited++;
      if (waited > STREAM_TIMEOUT) timeout_fail("out_valid");
    end
  endtask

  task automatic wait_run_done();
    logic [31:0] data;
    axi_resp_t   resp;
    int          polls;
    polls = 0;
    do begin
      axi_read(`VCOSH_ADDR_STATUS, data, resp);
      polls++;
      if (polls > POLL_LIMIT) timeout_fail("STATUS.DONE at the end of a run");
    end while (!data[1]);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_registers();
    axi_resp_t   resp;
    logic [31:0] data;
    expect_read(`VCOSH_ADDR_CTRL, 32'h0, "CTRL after reset");
    expect_read(`VCOSH_ADDR_SIZE, 32'h0, "SIZE after reset");
    expect_read(`VCOSH_ADDR_STATUS, 32'h0, "STATUS after reset");
    expect_read(`VCOSH_ADDR_COUNT, 32'h0, "COUNT after reset");
    write_ok(`VCOSH_ADDR_SIZE, 32'h0000_0123);
    expect_read(`VCOSH_ADDR_SIZE, 32'h0000_0123, "SIZE readback");
    // Status registers stay read only
    write_ok(`VCOSH_ADDR_STATUS, 32'hFFFF_FFFF);
    expect_read(`VCOSH_ADDR_STATUS, 32'h0, "STATUS after write");
    write_ok(`VCOSH_ADDR_COUNT, 32'h0000_1234);
    expect_read(`VCOSH_ADDR_COUNT, 32'h0, "COUNT after write");
    // Off the map
    axi_write(4'h1, 32'hDEAD_BEEF, resp);
    assert (resp == AXI_SLVERR)
      else check_fail($sformatf("unmapped write gave response %0d", resp));
    axi_read(4'h6, data, resp);
    assert (resp == AXI_SLVERR)
      else check_fail($sformatf("unmapped read gave response %0d", resp));
    assert (data == 32'h0)
      else check_fail($sformatf("unmapped read returned 0x%08h", data));
    write_ok(`VCOSH_ADDR_SIZE, 32'h0);
  endtask

  // Runs before any real run so DONE is still clear
  task automatic test_zero_size_start();
    write_ok(`VCOSH_ADDR_SIZE, 32'h0);
    write_ok(`VCOSH_ADDR_CTRL, 32'h1);
    expect_read(`VCOSH_ADDR_STATUS, 32'h0, "STATUS after START with SIZE zero");
    repeat (20) begin
      @(negedge CLK);
      assert (!in_ready)
        else check_fail("in_ready high after START with SIZE zero");
    end
    expect_read(`VCOSH_ADDR_COUNT, 32'h0, "COUNT after START with SIZE zero");
  endtask

  task automatic test_single();
    int base;
    base = out_count;
    stim[0] = 0;
    start_run(1);
    drive_stream(0, 1, 0);
    wait_run_done();
    assert (out_log[base] == ONE_Q)
      else check_fail($sformatf("cosh(0) gave %0d, expected %0d", out_log[base], ONE_Q));
    // Even function
    base = out_count;
    stim[0] = ONE_Q;
    stim[1] = -ONE_Q;
    start_run(2);
    drive_stream(0, 2, 0);
    wait_run_done();
    assert (out_log[base] == cosh_model(ONE_Q))
      else check_fail($sformatf("cosh(1.0) gave %0d", out_log[base]));
    assert (out_log[base + 1] == out_log[base])
      else check_fail($sformatf("cosh(-1.0) gave %0d, cosh(1.0) gave %0d",
                                out_log[base + 1], out_log[base]));
  endtask

  task automatic test_random_run();
    int base;
    base = out_count;
    for (int i = 0; i < 8; i++) stim[i] = rand_fixed();
    start_run(8);
    drive_stream(0, 8, 0);
    wait_run_done();
    assert (out_count - base == 8)
      else check_fail($sformatf("%0d outputs for 8 inputs", out_count - base));
    expect_read(`VCOSH_ADDR_STATUS, 32'h2, "STATUS after random run");
    expect_read(`VCOSH_ADDR_COUNT, 32'h8, "COUNT after random run");
  endtask

  task automatic test_flow_gaps();
    int base;
    base = out_count;
    for (int i = 0; i < 6; i++) stim[i] = rand_fixed();
    start_run(6);
    drive_stream(0, 6, 12);
    wait_run_done();
    assert (out_count - base == 6)
      else check_fail($sformatf("%0d outputs for 6 gapped inputs", out_count - base));
    expect_read(`VCOSH_ADDR_COUNT, 32'h6, "COUNT after gapped run");
  endtask

  task automatic test_busy_start();
    int base;
    base = out_count;
    for (int i = 0; i < 3; i++) stim[i] = rand_fixed();
    start_run(3);
    drive_stream(0, 1, 0);
    wait_outputs(base + 1);
    // Second START lands mid run
    write_ok(`VCOSH_ADDR_CTRL, 32'h1);
    expect_read(`VCOSH_ADDR_STATUS, 32'h1, "STATUS after START while busy");
    expect_read(`VCOSH_ADDR_COUNT, 32'h1, "COUNT after START while busy");
    drive_stream(1, 2, 0);
    wait_run_done();
    assert (out_count - base == 3)
      else check_fail($sformatf("%0d outputs for a 3 element run", out_count - base));
    expect_read(`VCOSH_ADDR_STATUS, 32'h2, "STATUS after interrupted run");
    expect_read(`VCOSH_ADDR_COUNT, 32'h3, "COUNT after interrupted run");
  endtask

  // Monitor checks the 9 cycle spacing on every output
  task automatic test_latency();
    int base;
    base = out_count;
    for (int i = 0; i < 5; i++) stim[i] = rand_fixed();
    start_run(5);
    drive_stream(0, 5, 3);
    wait_run_done();
    assert (out_count - base == 5)
      else check_fail($sformatf("%0d outputs in latency run", out_count - base));
    assert (pend_data.size() == 0)
      else check_fail("elements still pending after latency run");
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    RST           = 1'b1;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    in_data       = '0;
    in_valid      = 1'b0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    $display("Register access");
    test_registers();
    $display("START with SIZE zero");
    test_zero_size_start();
    $display("Single element runs");
    test_single();
    $display("Eight element random run");
    test_random_run();
    $display("Input gaps");
    test_flow_gaps();
    $display("START while busy");
    test_busy_start();
    $display("Latency");
    test_latency();

    if (fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/vcosh_pkg.sv
design/vcosh_csr.sv
design/scalar_cosh.sv
design/vector_cosh.sv
design/vcosh_top.sv
verification/vcosh_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
verilator --binary --timing --assert -f vlog.f --top-module vcosh_tb -o vcosh_sim \
  && ./obj_dir/vcosh_sim | tee /dev/stderr | grep -q -F 'All tests passed!' \
  && echo "Simulation OK" \
  || { echo "Simulation FAILED"; exit 1; }
